// File: dv/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
	parameter int HALF_PERIOD  = 50,
	parameter int RESET_CYCLES = 4
) (
	input  logic restart,
	output logic clock,
	output logic reset
);

	int remaining = RESET_CYCLES;

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

	// restart reloads the reset count.
	always @(posedge clock) begin
		if (restart) begin
			remaining <= RESET_CYCLES;
		end else if (remaining != 0) begin
			remaining <= remaining - 1;
		end
	end

	assign reset = remaining != 0;

endmodule

// File: dv/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb;

	localparam int LINES          = 16;
	localparam int MEM_WORDS      = 1024;
	localparam int MEM_LATENCY    = 3;
	localparam int INDEX_BITS     = $clog2(LINES);
	localparam int MEM_INDEX_BITS = $clog2(MEM_WORDS);
	localparam int TAG_SHIFT      = fetch_pkg::OFFSET_BITS + INDEX_BITS;

	localparam int NUM_RANDOM      = 200;
	localparam int NUM_FETCHES     = 3 + 3 + 8 + NUM_RANDOM + 3;
	localparam int WATCHDOG_CYCLES = NUM_FETCHES * (MEM_LATENCY + 20) + MEM_WORDS + 100;

	localparam logic [31:0] LFSR_SEED = 32'h2cec;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic             clock;
	logic             reset;
	logic             restart;
	fetch_pkg::addr_t fetch_addr;
	logic             fetch_valid;
	logic             fetch_ready;
	fetch_pkg::word_t fetch_data;
	logic             fetch_hit;
	logic             fetch_done;
	logic             mem_load_en;
	fetch_pkg::addr_t mem_load_addr;
	fetch_pkg::word_t mem_load_data;

	// expected result of the fetch in flight.
	fetch_pkg::word_t exp_data;
	logic             exp_hit;

	fetch_pkg::word_t loaded [MEM_WORDS];
	logic             ref_valid [LINES];
	fetch_pkg::addr_t ref_tag [LINES];
	logic [31:0]      lfsr_state = LFSR_SEED;

	int error_count = 0;
	int fetch_count = 0;
	int hit_count   = 0;
	int miss_count  = 0;

	clock_gen i_clock_gen (.restart, .clock, .reset);

	fetch_top #(
		.LINES(LINES),
		.MEM_WORDS(MEM_WORDS),
		.MEM_LATENCY(MEM_LATENCY)
	) i_dut (
		.clock, .reset,
		.fetch_addr, .fetch_valid, .fetch_ready, .fetch_data, .fetch_hit, .fetch_done,
		.mem_load_en, .mem_load_addr, .mem_load_data
	);

	// ------------------------------------------------------------------
	// random numbers and the direct-mapped model.
	// ------------------------------------------------------------------
	function automatic logic [31:0] next_bits(input int count);
		logic [31:0] value;
		logic        bit_out;
		value = '0;
		for (int n = 0; n < count; n++) begin
			bit_out    = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (bit_out) lfsr_state = lfsr_state ^ LFSR_TAPS;
			value = {value[30:0], bit_out};
		end
		return value;
	endfunction

	// mostly a small window so that lines get reused.
	function automatic fetch_pkg::addr_t random_addr();
		logic [31:0] word_index;
		if (next_bits(2) == 32'd0) begin
			word_index = next_bits(MEM_INDEX_BITS);
		end else begin
			word_index = next_bits(6);
		end
		return fetch_pkg::addr_t'(word_index << fetch_pkg::OFFSET_BITS);
	endfunction

	function automatic int line_of(input fetch_pkg::addr_t addr);
		return int'(addr[fetch_pkg::OFFSET_BITS +: INDEX_BITS]);
	endfunction

	function automatic fetch_pkg::addr_t tag_of(input fetch_pkg::addr_t addr);
		return addr >> TAG_SHIFT;
	endfunction

	function automatic int word_of(input fetch_pkg::addr_t addr);
		return int'(addr[fetch_pkg::OFFSET_BITS +: MEM_INDEX_BITS]);
	endfunction

	// ------------------------------------------------------------------
	// stimulus tasks.
	// ------------------------------------------------------------------
	task automatic load_memory();
		logic [31:0] word;
		for (int i = 0; i < MEM_WORDS; i++) begin
			word      = next_bits(32);
			loaded[i] = word;
			@(posedge clock);
			mem_load_en   <= 1'b1;
			mem_load_addr <= fetch_pkg::addr_t'(i) << fetch_pkg::OFFSET_BITS;
			mem_load_data <= word;
		end
		@(posedge clock);
		mem_load_en <= 1'b0;
	endtask

	task automatic run_fetch(input fetch_pkg::addr_t addr);
		int               line_index;
		fetch_pkg::addr_t tag;
		logic             predicted;
		line_index = line_of(addr);
		tag        = tag_of(addr);
		predicted  = ref_valid[line_index] && (ref_tag[line_index] == tag);
		do @(negedge clock); while (!fetch_ready);
		@(posedge clock);
		fetch_addr  <= addr;
		fetch_valid <= 1'b1;
		exp_hit     <= predicted;
		exp_data    <= loaded[word_of(addr)];
		// accepted on this edge.
		@(posedge clock);
		fetch_valid <= 1'b0;
		do @(negedge clock); while (!fetch_done);
		ref_valid[line_index] = 1'b1;
		ref_tag[line_index]   = tag;
		fetch_count++;
		if (predicted) hit_count++;
		else miss_count++;
	endtask

	task automatic pulse_reset();
		@(posedge clock);
		restart <= 1'b1;
		@(posedge clock);
		restart <= 1'b0;
		do @(negedge clock); while (reset);
		for (int i = 0; i < LINES; i++) ref_valid[i] = 1'b0;
	endtask

	// ------------------------------------------------------------------
	// checks.
	// ------------------------------------------------------------------
	a_data: assert property (@(posedge clock) disable iff (reset)
		fetch_done |-> fetch_data == exp_data)
	else begin
		error_count++;
		$display("FAIL %0t fetch_data: got %h expected %h",
			$time, $sampled(fetch_data), $sampled(exp_data));
	end

	a_hit: assert property (@(posedge clock) disable iff (reset)
		fetch_done |-> fetch_hit == exp_hit)
	else begin
		error_count++;
		$display("FAIL %0t fetch_hit: got %0b expected %0b",
			$time, $sampled(fetch_hit), $sampled(exp_hit));
	end

	a_idle_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> fetch_ready && !fetch_done)
	else begin
		error_count++;
		$display("at %0t the fetch port was not idle right after reset", $time);
	end

	a_hit_latency: assert property (@(posedge clock) disable iff (reset)
		fetch_valid && fetch_ready && exp_hit |-> ##3 fetch_done)
	else begin
		error_count++;
		$display("at %0t a hit did not complete 3 cycles after its accept", $time);
	end

	a_done_pulse: assert property (@(posedge clock) disable iff (reset)
		fetch_done |=> !fetch_done)
	else begin
		error_count++;
		$display("at %0t fetch_done stayed high for more than one cycle", $time);
	end

	a_ready_drops: assert property (@(posedge clock) disable iff (reset)
		fetch_valid && fetch_ready |=> !fetch_ready)
	else begin
		error_count++;
		$display("at %0t fetch_ready stayed high after an accept", $time);
	end

	a_busy_at_done: assert property (@(posedge clock) disable iff (reset)
		fetch_done |-> !fetch_ready)
	else begin
		error_count++;
		$display("at %0t fetch_ready was high together with fetch_done", $time);
	end

	a_ready_after_done: assert property (@(posedge clock) disable iff (reset)
		fetch_done |=> fetch_ready)
	else begin
		error_count++;
		$display("at %0t fetch_ready did not return after fetch_done", $time);
	end

	a_ready_rise: assert property (@(posedge clock) disable iff (reset)
		$rose(fetch_ready) |-> $past(fetch_done))
	else begin
		error_count++;
		$display("at %0t fetch_ready rose without a preceding fetch_done", $time);
	end

	// ------------------------------------------------------------------
	// test sequence.
	// ------------------------------------------------------------------
	initial begin
		restart       <= 1'b0;
		fetch_addr    <= '0;
		fetch_valid   <= 1'b0;
		mem_load_en   <= 1'b0;
		mem_load_addr <= '0;
		mem_load_data <= '0;
		exp_data      <= '0;
		exp_hit       <= 1'b0;
		for (int i = 0; i < LINES; i++) begin
			ref_valid[i] = 1'b0;
			ref_tag[i]   = '0;
		end
		do @(negedge clock); while (reset);
		load_memory();

		// first fetches miss and repeats hit.
		run_fetch(32'h0000_0000);
		run_fetch(32'h0000_0104);
		run_fetch(32'h0000_0ffc);
		run_fetch(32'h0000_0000);
		run_fetch(32'h0000_0104);
		run_fetch(32'h0000_0ffc);

		// two tags on the same line.
		for (int i = 0; i < 4; i++) begin
			run_fetch(32'h0000_0200);
			run_fetch(32'h0000_0600);
		end

		for (int i = 0; i < NUM_RANDOM; i++) run_fetch(random_addr());

		run_fetch(32'h0000_0104);
		pulse_reset();
		run_fetch(32'h0000_0104);
		run_fetch(32'h0000_0104);

		$display("errors: %0d, fetches: %0d (hits %0d, misses %0d)",
			error_count, fetch_count, hit_count, miss_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("errors: %0d, fetches: %0d (hits %0d, misses %0d)",
			error_count, fetch_count, hit_count, miss_count);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: files.f
source/fetch_pkg.sv
source/icache_store.sv
source/refill_ctrl.sv
source/instr_mem.sv
source/fetch_top.sv
dv/clock_gen.sv
dv/fetch_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the fetch testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f files.f --top-module fetch_tb -o fetch_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output="$(./obj_dir/fetch_sim)"
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1

// File: source/fetch_pkg.sv
package fetch_pkg;

	// ------------------------------------------------------------------
	// bus widths.
	// ------------------------------------------------------------------
	localparam int ADDR_BITS = 32;
	localparam int WORD_BITS = 32;

	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [1:0]           resp_t;

	// ------------------------------------------------------------------
	// channel encodings.
	// ------------------------------------------------------------------
	// lookups flag a miss in bit 1.
	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_MISS = 2'b10;

	localparam int STRB_BITS = 4;
	localparam logic [STRB_BITS-1:0] STRB_FULL = '1;

	// byte-in-word bits below the line index.
	localparam int OFFSET_BITS = 2;

endpackage

// File: source/fetch_top.sv
`timescale 1ns/10ps

module fetch_top #(
	parameter int LINES       = 16,
	parameter int MEM_WORDS   = 1024,
	parameter int MEM_LATENCY = 3
) (
	input  logic             clock,
	input  logic             reset,

	input  fetch_pkg::addr_t fetch_addr,
	input  logic             fetch_valid,
	output logic             fetch_ready,
	output fetch_pkg::word_t fetch_data,
	output logic             fetch_hit,
	output logic             fetch_done,

	input  logic             mem_load_en,
	input  fetch_pkg::addr_t mem_load_addr,
	input  fetch_pkg::word_t mem_load_data
);

	// ------------------------------------------------------------------
	// cache channels.
	// ------------------------------------------------------------------
	fetch_pkg::addr_t                araddr;
	logic                            arvalid;
	logic                            arready;
	fetch_pkg::word_t                rdata;
	fetch_pkg::resp_t                rresp;
	logic                            rvalid;
	logic                            rready;
	fetch_pkg::addr_t                awaddr;
	logic                            awvalid;
	logic                            awready;
	fetch_pkg::word_t                wdata;
	logic [fetch_pkg::STRB_BITS-1:0] wstrb;
	logic                            wvalid;
	logic                            wready;
	fetch_pkg::resp_t                bresp;
	logic                            bvalid;
	logic                            bready;

	// memory read port.
	logic                            mem_rd_en;
	fetch_pkg::addr_t                mem_rd_addr;
	fetch_pkg::word_t                mem_rd_data;
	logic                            mem_rd_valid;

	refill_ctrl #(.LINES(LINES)) i_refill_ctrl (
		.clock, .reset,
		.fetch_addr, .fetch_valid, .fetch_ready, .fetch_data, .fetch_hit, .fetch_done,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.mem_rd_en, .mem_rd_addr, .mem_rd_data, .mem_rd_valid
	);

	icache_store #(.LINES(LINES)) i_icache_store (
		.clock, .reset,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready
	);

	instr_mem #(.MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY)) i_instr_mem (
		.clock, .reset,
		.mem_load_en, .mem_load_addr, .mem_load_data,
		.mem_rd_en, .mem_rd_addr, .mem_rd_data, .mem_rd_valid
	);

endmodule

// File: source/icache_store.sv
`timescale 1ns/10ps

module icache_store #(
	parameter int LINES = 16
) (
	input  logic                               clock,
	input  logic                               reset,

	input  fetch_pkg::addr_t                   araddr,
	input  logic                               arvalid,
	output logic                               arready,

	output fetch_pkg::word_t                   rdata,
	output fetch_pkg::resp_t                   rresp,
	output logic                               rvalid,
	input  logic                               rready,

	input  fetch_pkg::addr_t                   awaddr,
	input  logic                               awvalid,
	output logic                               awready,

	input  fetch_pkg::word_t                   wdata,
	input  logic [fetch_pkg::STRB_BITS-1:0]    wstrb,
	input  logic                               wvalid,
	output logic                               wready,

	output fetch_pkg::resp_t                   bresp,
	output logic                               bvalid,
	input  logic                               bready
);

	localparam int INDEX_BITS = $clog2(LINES);
	localparam int TAG_BITS   = fetch_pkg::ADDR_BITS - INDEX_BITS - fetch_pkg::OFFSET_BITS;

	// ------------------------------------------------------------------
	// line arrays.
	// ------------------------------------------------------------------
	logic [LINES-1:0]        line_valid;
	logic [TAG_BITS-1:0]     line_tag  [LINES];
	fetch_pkg::word_t        line_data [LINES];

	logic [INDEX_BITS-1:0]   read_index;
	logic [TAG_BITS-1:0]     read_tag;
	logic                    lookup_hit;

	fetch_pkg::addr_t        fill_addr;
	fetch_pkg::word_t        fill_data;
	logic                    addr_held;
	logic                    data_held;
	logic [INDEX_BITS-1:0]   write_index;
	logic [TAG_BITS-1:0]     write_tag;
	logic                    commit;

	logic ar_fire;
	logic r_fire;
	logic aw_fire;
	logic w_fire;
	logic b_fire;

	assign ar_fire = arvalid & arready;
	assign r_fire  = rvalid & rready;
	assign aw_fire = awvalid & awready;
	assign w_fire  = wvalid & wready;
	assign b_fire  = bvalid & bready;

	assign read_index = araddr[fetch_pkg::OFFSET_BITS +: INDEX_BITS];
	assign read_tag   = araddr[fetch_pkg::ADDR_BITS-1 -: TAG_BITS];
	assign lookup_hit = line_valid[read_index] & (line_tag[read_index] == read_tag);

	assign write_index = fill_addr[fetch_pkg::OFFSET_BITS +: INDEX_BITS];
	assign write_tag   = fill_addr[fetch_pkg::ADDR_BITS-1 -: TAG_BITS];

	// address and data both in hand.
	assign commit = addr_held & data_held;

	// ------------------------------------------------------------------
	// read channels.
	// ------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			arready <= 1'b1;
		end else if (ar_fire) begin
			arready <= 1'b0;
		end else if (r_fire) begin
			arready <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rvalid <= 1'b0;
		end else if (ar_fire) begin
			rvalid <= 1'b1;
		end else if (r_fire) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			rdata <= line_data[read_index];
			rresp <= lookup_hit ? fetch_pkg::RESP_OKAY : fetch_pkg::RESP_MISS;
		end
	end

	// ------------------------------------------------------------------
	// write channels.
	// ------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			awready <= 1'b1;
		end else if (aw_fire) begin
			awready <= 1'b0;
		end else if (b_fire) begin
			awready <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wready <= 1'b1;
		end else if (w_fire) begin
			wready <= 1'b0;
		end else if (b_fire) begin
			wready <= 1'b1;
		end
	end

	// each half is latched on its own.
	always_ff @(posedge clock) begin
		if (reset) begin
			addr_held <= 1'b0;
			data_held <= 1'b0;
		end else if (commit) begin
			addr_held <= 1'b0;
			data_held <= 1'b0;
		end else begin
			if (aw_fire) addr_held <= 1'b1;
			if (w_fire) data_held <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire) fill_addr <= awaddr;
		if (w_fire) fill_data <= wdata;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			bvalid <= 1'b0;
		end else if (commit) begin
			bvalid <= 1'b1;
		end else if (b_fire) begin
			bvalid <= 1'b0;
		end
	end

	assign bresp = fetch_pkg::RESP_OKAY;

	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
		end else if (commit) begin
			line_valid[write_index] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (commit) begin
			line_tag[write_index]  <= write_tag;
			line_data[write_index] <= fill_data;
		end
	end

	// ------------------------------------------------------------------
	// checks.
	// ------------------------------------------------------------------
	a_full_strobe: assert property (@(posedge clock) disable iff (reset)
		wvalid |-> wstrb == fetch_pkg::STRB_FULL);

	a_one_read: assert property (@(posedge clock) disable iff (reset)
		!(rvalid && arready));

	a_bresp_okay: assert property (@(posedge clock) disable iff (reset)
		bvalid |-> bresp == fetch_pkg::RESP_OKAY);

endmodule

// File: source/instr_mem.sv
`timescale 1ns/10ps

module instr_mem #(
	parameter int MEM_WORDS   = 1024,
	parameter int MEM_LATENCY = 3
) (
	input  logic             clock,
	input  logic             reset,

	input  logic             mem_load_en,
	input  fetch_pkg::addr_t mem_load_addr,
	input  fetch_pkg::word_t mem_load_data,

	input  logic             mem_rd_en,
	input  fetch_pkg::addr_t mem_rd_addr,
	output fetch_pkg::word_t mem_rd_data,
	output logic             mem_rd_valid
);

	localparam int IDX_BITS = $clog2(MEM_WORDS);

	fetch_pkg::word_t       mem [MEM_WORDS];
	logic [IDX_BITS-1:0]    load_index;
	logic [IDX_BITS-1:0]    rd_index;

	logic [MEM_LATENCY-1:0] valid_pipe;
	fetch_pkg::word_t       data_pipe [MEM_LATENCY];

	// word addressed.
	assign load_index = mem_load_addr[fetch_pkg::OFFSET_BITS +: IDX_BITS];
	assign rd_index   = mem_rd_addr[fetch_pkg::OFFSET_BITS +: IDX_BITS];

	always_ff @(posedge clock) begin
		if (mem_load_en) mem[load_index] <= mem_load_data;
	end

	// ------------------------------------------------------------------
	// latency pipe.
	// ------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe[0] <= mem_rd_en;
			for (int i = 1; i < MEM_LATENCY; i++) valid_pipe[i] <= valid_pipe[i-1];
		end
	end

	// old word wins against a same-cycle load.
	always_ff @(posedge clock) begin
		data_pipe[0] <= mem[rd_index];
		for (int i = 1; i < MEM_LATENCY; i++) data_pipe[i] <= data_pipe[i-1];
	end

	assign mem_rd_valid = valid_pipe[MEM_LATENCY-1];
	assign mem_rd_data  = data_pipe[MEM_LATENCY-1];

	a_one_in_flight: assert property (@(posedge clock) disable iff (reset)
		mem_rd_en |-> valid_pipe == '0);

endmodule

// File: source/refill_ctrl.sv
`timescale 1ns/10ps

module refill_ctrl #(
	parameter int LINES = 16
) (
	input  logic                               clock,
	input  logic                               reset,

	input  fetch_pkg::addr_t                   fetch_addr,
	input  logic                               fetch_valid,
	output logic                               fetch_ready,
	output fetch_pkg::word_t                   fetch_data,
	output logic                               fetch_hit,
	output logic                               fetch_done,

	output fetch_pkg::addr_t                   araddr,
	output logic                               arvalid,
	input  logic                               arready,
	input  fetch_pkg::word_t                   rdata,
	input  fetch_pkg::resp_t                   rresp,
	input  logic                               rvalid,
	output logic                               rready,
	output fetch_pkg::addr_t                   awaddr,
	output logic                               awvalid,
	input  logic                               awready,
	output fetch_pkg::word_t                   wdata,
	output logic [fetch_pkg::STRB_BITS-1:0]    wstrb,
	output logic                               wvalid,
	input  logic                               wready,
	input  fetch_pkg::resp_t                   bresp,
	input  logic                               bvalid,
	output logic                               bready,

	output logic                               mem_rd_en,
	output fetch_pkg::addr_t                   mem_rd_addr,
	input  fetch_pkg::word_t                   mem_rd_data,
	input  logic                               mem_rd_valid
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_RESULT,
		S_MEM_READ,
		S_MEM_WAIT,
		S_FILL,
		S_DONE
	} state_t;

	state_t           state;
	fetch_pkg::addr_t req_addr;
	fetch_pkg::word_t fill_word;
	logic             replay;
	logic             aw_sent;
	logic             w_sent;
	logic             rd_outstanding;

	// index is taken straight from the address so lines must be a power of two.
	if (LINES != (1 << $clog2(LINES))) begin : g_lines_check
		$error("LINES must be a power of two");
	end

	assign fetch_ready = state == S_IDLE;
	assign fetch_done  = state == S_DONE;

	assign araddr  = req_addr;
	assign arvalid = state == S_LOOKUP;
	assign rready  = state == S_RESULT;

	assign awaddr  = req_addr;
	assign awvalid = (state == S_FILL) & ~aw_sent;
	assign wdata   = fill_word;
	assign wstrb   = fetch_pkg::STRB_FULL;
	assign wvalid  = (state == S_FILL) & ~w_sent;
	assign bready  = state == S_FILL;

	assign mem_rd_en   = state == S_MEM_READ;
	assign mem_rd_addr = req_addr;

	// ------------------------------------------------------------------
	// sequencing.
	// ------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= S_IDLE;
			replay    <= 1'b0;
			fetch_hit <= 1'b0;
			aw_sent   <= 1'b0;
			w_sent    <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (fetch_valid) begin
					replay <= 1'b0;
					state  <= S_LOOKUP;
				end
				S_LOOKUP: if (arready) state <= S_RESULT;
				S_RESULT: if (rvalid) begin
					if (rresp[1] && !replay) begin
						replay <= 1'b1;
						state  <= S_MEM_READ;
					end else begin
						fetch_hit <= ~replay;
						state     <= S_DONE;
					end
				end
				S_MEM_READ: state <= S_MEM_WAIT;
				S_MEM_WAIT: if (mem_rd_valid) state <= S_FILL;
				S_FILL: begin
					if (awvalid && awready) aw_sent <= 1'b1;
					if (wvalid && wready) w_sent <= 1'b1;
					// replay the lookup once the fill is acknowledged.
					if (bvalid && bresp == fetch_pkg::RESP_OKAY) begin
						aw_sent <= 1'b0;
						w_sent  <= 1'b0;
						state   <= S_LOOKUP;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_ready && fetch_valid) req_addr <= fetch_addr;
		if (state == S_MEM_WAIT && mem_rd_valid) fill_word <= mem_rd_data;
		if (state == S_RESULT && rvalid) fetch_data <= rdata;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_outstanding <= 1'b0;
		end else if (mem_rd_en) begin
			rd_outstanding <= 1'b1;
		end else if (mem_rd_valid) begin
			rd_outstanding <= 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// checks.
	// ------------------------------------------------------------------
	a_single_read: assert property (@(posedge clock) disable iff (reset)
		mem_rd_en |-> !rd_outstanding);

	a_replay_hits: assert property (@(posedge clock) disable iff (reset)
		(state == S_RESULT && rvalid && replay) |-> !rresp[1]);

endmodule
